// File: design/align_monitor.sv
`timescale 1ns/1ps

module align_monitor import vid_pkg::*, deskew_pkg::*; (
    input  logic       PCLK_I,
    input  logic       arst,
    input  port_cnt_t  port_cnt,
    input  port_mask_t aligned_de,
    output port_mask_t active_mask,
    output logic       misaligned,
    output logic       flush,
    output logic       rx_reset,
    output accus_cnt_t accus,
    output round_cnt_t rounds,
    output retry_cnt_t retries
);

    retry_state_t state;
    round_cnt_t   win_cnt;     // protect window countdown
    round_cnt_t   rx_cnt;      // rx_reset countdown
    logic         retry_pulse;

    ////////////////////////////////////////
    // active ports and misalignment
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < port_num; i++) begin
            active_mask[i] = (port_cnt_t'(i) < port_cnt); // low ports only
        end
    end

    // inactive bits read as 1 for the all-one test, 0 for the all-zero test
    assign misaligned = ~flush
                      & ((aligned_de | ~active_mask) != '1)
                      & ((aligned_de & active_mask) != '0);

    assign retry_pulse = (state == run) && (rounds == round_cnt_t'(misalign_thresh));
    assign flush       = (state == protect);

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////
    always_ff @(posedge PCLK_I) begin
        if (arst) begin
            accus   <= '0;
            rounds  <= '0;
            retries <= '0;
        end else begin
            accus <= accus + accus_cnt_t'(misaligned);
            if (retry_pulse) begin
                rounds  <= '0;                  // new round
                retries <= retries + 1'b1;
            end else begin
                rounds <= rounds + round_cnt_t'(misaligned);
            end
        end
    end

    ////////////////////////////////////////
    // retry fsm
    ////////////////////////////////////////
    always_ff @(posedge PCLK_I) begin
        if (arst) begin
            state   <= run;
            win_cnt <= '0;
        end else begin
            case (state)
                run: begin
                    if (retry_pulse) begin
                        state   <= protect;
                        win_cnt <= round_cnt_t'(protect_cycles - 1);
                    end
                end
                protect: begin
                    if (win_cnt == '0) begin
                        state <= settle;
                    end else begin
                        win_cnt <= win_cnt - 1'b1;
                    end
                end
                settle: begin
                    if (!rx_reset) begin
                        state <= run; // receiver is back up so counting rearms
                    end
                end
                default: state <= run;
            endcase
        end
    end

    // stretched deserializer reset
    always_ff @(posedge PCLK_I) begin
        if (arst) begin
            rx_reset <= 1'b0;
            rx_cnt   <= '0;
        end else if (retry_pulse) begin
            rx_reset <= 1'b1;
            rx_cnt   <= round_cnt_t'(rx_reset_cycles - 1);
        end else if (rx_cnt != '0) begin
            rx_cnt <= rx_cnt - 1'b1;
        end else begin
            rx_reset <= 1'b0;
        end
    end

    // single pulse, no repeat while the receiver reset runs its full length
    a_retry_one_hot: assert property (@(posedge PCLK_I) disable iff (arst)
        retry_pulse |=> (!retry_pulse && rx_reset) [*rx_reset_cycles] ##1 !rx_reset);

endmodule

// File: design/aligned_readout.sv
`timescale 1ns/1ps

module aligned_readout import vid_pkg::*; (
    input  logic       PCLK_I,
    input  logic       arst,
    input  logic       flush,
    input  pix_bus_t   fifo_data,
    input  port_mask_t prog_empty,
    input  port_mask_t active_mask,
    input  logic       misaligned,
    output logic       rd_en,
    output port_mask_t aligned_de,
    output pix_bus_t   pix_out
);

    logic rd_vld; // fifo_data holds a fresh word

    ////////////////////////////////////////
    // common read enable
    ////////////////////////////////////////
    // idle ports are masked out of the empty check
    assign rd_en = ~|(prog_empty & active_mask) & ~misaligned & ~flush;

    always_comb begin
        for (int i = 0; i < port_num; i++) begin
            aligned_de[i] = fifo_data[i].de;
        end
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////
    always_ff @(posedge PCLK_I) begin
        if (arst || flush) begin
            rd_vld  <= 1'b0;
            pix_out <= '0;
        end else begin
            rd_vld <= rd_en;
            for (int i = 0; i < port_num; i++) begin
                // stalled read gives blank pixels, not repeats
                pix_out[i] <= rd_vld ? fifo_data[i] : '0;
            end
        end
    end

endmodule

// File: design/deskew_pkg.sv
package deskew_pkg;

    ////////////////////////////////////////
    // skew fifo sizing
    ////////////////////////////////////////
    localparam int fifo_depth        = 32;
    localparam int prog_empty_thresh = 4; // empty while count <= this

    typedef logic [4:0] fifo_addr_t;
    typedef logic [5:0] fifo_cnt_t;       // 0 .. fifo_depth

    ////////////////////////////////////////
    // misalignment handling
    ////////////////////////////////////////
    localparam int misalign_thresh = 16;  // misaligned cycles per round before retry
    localparam int protect_cycles  = 32;  // datapath clear after retry
    localparam int rx_reset_cycles = 20;  // deserializer reset length

    typedef logic [15:0] round_cnt_t;
    typedef logic [31:0] accus_cnt_t;
    typedef logic [15:0] retry_cnt_t;

    typedef enum logic [1:0] {
        run,
        protect,
        settle
    } retry_state_t;

endpackage

// File: design/native_deskew.sv
`timescale 1ns/1ps

module native_deskew import vid_pkg::*, deskew_pkg::*; (
    input  logic       PCLK_I,
    input  logic       arst,
    input  port_cnt_t  port_cnt,
    input  pix_bus_t   pix_in,
    output pix_bus_t   pix_out,
    output logic       misaligned,
    output accus_cnt_t accus,
    output round_cnt_t rounds,
    output retry_cnt_t retries,
    output logic       rx_reset
);

    wire pix_bus_t   wr_data;
    wire pix_bus_t   rd_data;
    wire port_mask_t wr_en;
    wire port_mask_t prog_empty;
    wire port_mask_t port_flush;

    port_mask_t active_mask;
    port_mask_t aligned_de;
    logic       rd_en;
    logic       flush;

    ////////////////////////////////////////
    // per port capture and skew fifo
    ////////////////////////////////////////
    for (genvar i = 0; i < port_num; i++) begin : g_port
        assign port_flush[i] = flush | ~active_mask[i]; // idle ports held clear

        port_capture capture_i (
            .PCLK_I  (PCLK_I),
            .arst    (arst),
            .flush   (port_flush[i]),
            .pix_in  (pix_in[i]),
            .wr_en   (wr_en[i]),
            .wr_data (wr_data[i])
        );

        skew_fifo fifo_i (
            .PCLK_I     (PCLK_I),
            .arst       (arst),
            .flush      (port_flush[i]),
            .wr_en      (wr_en[i]),
            .wr_data    (wr_data[i]),
            .rd_en      (rd_en),
            .rd_data    (rd_data[i]),
            .prog_empty (prog_empty[i])
        );
    end

    ////////////////////////////////////////
    // readout and monitor
    ////////////////////////////////////////
    aligned_readout readout_i (
        .PCLK_I      (PCLK_I),
        .arst        (arst),
        .flush       (flush),
        .fifo_data   (rd_data),
        .prog_empty  (prog_empty),
        .active_mask (active_mask),
        .misaligned  (misaligned),
        .rd_en       (rd_en),
        .aligned_de  (aligned_de),
        .pix_out     (pix_out)
    );

    align_monitor monitor_i (
        .PCLK_I      (PCLK_I),
        .arst        (arst),
        .port_cnt    (port_cnt),
        .aligned_de  (aligned_de),
        .active_mask (active_mask),
        .misaligned  (misaligned),
        .flush       (flush),
        .rx_reset    (rx_reset),
        .accus       (accus),
        .rounds      (rounds),
        .retries     (retries)
    );

endmodule

// File: design/port_capture.sv
`timescale 1ns/1ps

module port_capture import vid_pkg::*; (
    input  logic PCLK_I,
    input  logic arst,
    input  logic flush,
    input  pix_t pix_in,
    output logic wr_en,
    output pix_t wr_data
);

    pix_t pix_q;      // registered port input
    logic de_prev;    // de of the previous cycle
    logic start_flag; // set once a line end was seen
    logic de_rise;
    logic de_fall;

    assign de_rise = ~de_prev & pix_q.de;
    assign de_fall = de_prev & ~pix_q.de;

    ////////////////////////////////////////
    // input register
    ////////////////////////////////////////
    always_ff @(posedge PCLK_I) begin
        if (arst || flush) begin
            pix_q   <= '0;
            de_prev <= 1'b0;
        end else begin
            pix_q   <= pix_in;
            de_prev <= pix_q.de;
        end
    end

    ////////////////////////////////////////
    // write arming
    ////////////////////////////////////////
    // wait for a falling de first, so a port never starts mid line
    always_ff @(posedge PCLK_I) begin
        if (arst || flush) begin
            start_flag <= 1'b0;
            wr_en      <= 1'b0;
        end else begin
            if (de_fall) begin
                start_flag <= 1'b1;
            end
            if (de_rise && start_flag) begin
                wr_en <= 1'b1; // stays on until the next flush
            end
        end
    end

    assign wr_data = pix_q;

endmodule

// File: design/skew_fifo.sv
`timescale 1ns/1ps

module skew_fifo import vid_pkg::*, deskew_pkg::*; (
    input  logic PCLK_I,
    input  logic arst,
    input  logic flush,
    input  logic wr_en,
    input  pix_t wr_data,
    input  logic rd_en,
    output pix_t rd_data,
    output logic prog_empty
);

    pix_t       mem [fifo_depth];
    fifo_addr_t wr_ptr;
    fifo_addr_t rd_ptr;
    fifo_cnt_t  count;   // words held
    logic       wr_ok;
    logic       rd_ok;

    assign wr_ok = wr_en & ~flush;
    assign rd_ok = rd_en & ~flush;

    // reads are held off until enough skew margin has built up
    assign prog_empty = (count <= fifo_cnt_t'(prog_empty_thresh));

    always_ff @(posedge PCLK_I) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge PCLK_I) begin
        if (arst || flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            rd_data <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at fifo_depth
            end
            if (rd_ok) begin
                rd_ptr  <= rd_ptr + 1'b1;
                rd_data <= mem[rd_ptr]; // standard mode, one cycle late
            end
            count <= count + fifo_cnt_t'(wr_ok) - fifo_cnt_t'(rd_ok);
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    // capture has no ready, the shared read must keep pace
    a_no_overflow: assert property (@(posedge PCLK_I) disable iff (arst || flush)
        wr_en |-> (count != fifo_cnt_t'(fifo_depth)) || rd_en);

    // shared read enable must respect this port's fill level
    a_no_underflow: assert property (@(posedge PCLK_I) disable iff (arst || flush)
        rd_en |-> (count != '0));

endmodule

// File: design/vid_pkg.sv
package vid_pkg;

    ////////////////////////////////////////
    // port and lane geometry
    ////////////////////////////////////////
    localparam int port_num = 4;          // parallel input ports
    localparam int lane_num = 4;          // lanes per port
    localparam int chan_w   = 2 * lane_num; // bits per colour channel

    typedef logic [chan_w-1:0] chan_t;

    // one port's pixel, sync bits on top
    typedef struct packed {
        logic  vs;
        logic  hs;
        logic  de;
        chan_t r;
        chan_t g;
        chan_t b;
    } pix_t;

    // all ports side by side, port 0 in the low bits
    typedef pix_t [port_num-1:0] pix_bus_t;

    ////////////////////////////////////////
    // port selection
    ////////////////////////////////////////
    typedef logic [port_num-1:0] port_mask_t; // one bit per port
    typedef logic [3:0]          port_cnt_t;  // number of ports in use

endpackage

// File: tb.f
+incdir+verif
design/vid_pkg.sv
design/deskew_pkg.sv
design/port_capture.sv
design/skew_fifo.sv
design/aligned_readout.sv
design/align_monitor.sv
design/native_deskew.sv
verif/deskew_tb.sv

// File: verif/deskew_tests.svh
////////////////////////////////////////
// run control
////////////////////////////////////////
task automatic start_run(input port_cnt_t cnt, input int step, input logic garbage);
    @(negedge PCLK_I);
    arst       <= 1'b1;
    stream_on  <= 1'b0;
    fault_on   <= 1'b0;
    chk_en     <= 1'b0;
    garbage_hi <= garbage;
    port_cnt   <= cnt;
    for (int p = 0; p < port_num; p++) begin
        delay[p] <= step * p; // port k lags by step*k cycles
    end
    repeat (10) @(negedge PCLK_I);
    arst      <= 1'b0;
    stream_on <= 1'b1;
    chk_en    <= 1'b1;
endtask

task automatic wait_pixels(input int n, input string what);
    int k;
    k = 0;
    while (de_cnt[0] < n && k < 1000) begin
        @(negedge PCLK_I);
        k++;
    end
    if (de_cnt[0] < n) begin
        report_timeout(what);
    end
endtask

task automatic end_test(input string name, input int err0);
    tests_run++;
    if (errors != err0) begin
        tests_failed++;
        $display("%s: %0d errors", name, errors - err0);
    end else begin
        $display("%s: ok", name);
    end
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////
task automatic test_reset_values();
    int err0;
    err0 = errors;
    start_run(4, 0, 1'b0);
    if (pix_out != '0 || misaligned || rx_reset) begin
        report_mismatch("outputs not clear after reset");
    end
    if (accus != 0 || rounds != 0 || retries != 0) begin
        report_mismatch("counters not clear after reset");
    end
    end_test("reset_values", err0);
endtask

// step 0 means no skew
task automatic test_aligned(input string name, input port_cnt_t cnt, input int step,
                            input logic garbage);
    int err0;
    err0 = errors;
    start_run(cnt, step, garbage);
    wait_pixels(4 * line_len, "aligned output");
    if (accus != 0) begin
        report_mismatch($sformatf("accus %0d, expected 0", accus));
    end
    end_test(name, err0);
endtask

task automatic test_retry();
    int         err0;
    int         k;
    int         hi_cnt;
    retry_cnt_t r0;
    round_cnt_t last_rounds;
    err0 = errors;
    start_run(4, 2, 1'b0);
    wait_pixels(2 * line_len, "output before the fault");
    chk_en   <= 1'b0;
    fault_on <= 1'b1;
    r0 = retries;
    k  = 0;
    while (!misaligned && k < 500) begin
        @(negedge PCLK_I);
        k++;
    end
    if (!misaligned) begin
        report_timeout("misaligned to rise");
    end
    k           = 0;
    last_rounds = rounds;
    while (retries == r0 && k < 500) begin
        last_rounds = rounds;
        @(negedge PCLK_I);
        k++;
    end
    if (retries == r0) begin
        report_timeout("a retry");
    end else begin
        fault_on <= 1'b0; // stream is clean before the flush ends
        if (last_rounds != misalign_thresh || rounds != 0) begin
            report_mismatch($sformatf("round count %0d before retry", last_rounds));
        end
        if (retries != r0 + 1'b1 || accus < misalign_thresh) begin
            report_mismatch($sformatf("retries %0d, accus %0d", retries, accus));
        end
        hi_cnt = 0;
        for (int i = 0; i < protect_cycles; i++) begin
            if (rx_reset) begin
                hi_cnt++;
            end
            if (pix_out != '0 || misaligned) begin
                report_mismatch("outputs not clear during flush");
            end
            @(negedge PCLK_I);
        end
        if (hi_cnt != rx_reset_cycles) begin
            report_mismatch($sformatf("rx_reset high %0d cycles", hi_cnt));
        end
        chk_en <= 1'b1;
        wait_pixels(de_cnt[0] + 4 * line_len, "realigned output");
        if (retries != r0 + 1'b1) begin
            report_mismatch("extra retry after the fault stopped");
        end
    end
    end_test("retry", err0);
endtask

// File: verif/deskew_tb.sv
`timescale 1ns/1ps

module deskew_tb import vid_pkg::*, deskew_pkg::*; ();

    localparam int gap_len  = 8;  // blank cycles ahead of each line
    localparam int line_len = 12; // de pixels per line
    localparam int line_per = gap_len + line_len;

    logic       PCLK_I = 1'b0;
    logic       arst;
    port_cnt_t  port_cnt;
    pix_bus_t   pix_in;
    pix_bus_t   pix_out;
    logic       misaligned;
    logic       rx_reset;
    accus_cnt_t accus;
    round_cnt_t rounds;
    retry_cnt_t retries;

    logic       stream_on;
    logic       fault_on;   // port 1 loses one de pixel per line
    logic       garbage_hi; // random words on ports 2 and 3
    logic       chk_en;
    int         delay [port_num];
    int         t_cnt;      // cycles since the stream started
    integer     seed;

    logic [port_num-1:0] synced; // port has seen its first output pixel
    int         exp_idx [port_num];
    int         de_cnt [port_num];
    int         errors;
    int         tests_run;
    int         tests_failed;

    always #50 PCLK_I = ~PCLK_I;

    native_deskew dut_i (
        .PCLK_I     (PCLK_I),
        .arst       (arst),
        .port_cnt   (port_cnt),
        .pix_in     (pix_in),
        .pix_out    (pix_out),
        .misaligned (misaligned),
        .accus      (accus),
        .rounds     (rounds),
        .retries    (retries),
        .rx_reset   (rx_reset)
    );

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    ////////////////////////////////////////
    // stream driver
    ////////////////////////////////////////
    // line pattern seen delay[p] cycles late, port number in r
    function automatic pix_t stream_pix(input int p, input logic drop);
        pix_t px;
        int   lt;
        int   pos;
        px  = '0;
        lt  = t_cnt - delay[p];
        pos = lt % line_per;
        if (lt >= 0 && pos >= gap_len) begin
            px.de        = !(drop && pos == gap_len + 5);
            px.r         = chan_t'(p);
            {px.g, px.b} = 16'((lt / line_per) * line_len + pos - gap_len); // running index
        end else begin
            px.hs = 1'b1;
        end
        return px;
    endfunction

    always @(negedge PCLK_I) begin : drive
        logic [31:0] rnd;
        for (int p = 0; p < port_num; p++) begin
            rnd = $random(seed);
            if (!stream_on) begin
                pix_in[p] <= '0;
            end else if (garbage_hi && p >= 2) begin
                pix_in[p] <= rnd[$bits(pix_t)-1:0];
            end else begin
                pix_in[p] <= stream_pix(p, fault_on && p == 1);
            end
        end
        t_cnt <= stream_on ? t_cnt + 1 : 0;
    end

    ////////////////////////////////////////
    // output scoreboard
    ////////////////////////////////////////
    always @(negedge PCLK_I) begin : score
        int idx;
        if (arst) begin
            for (int p = 0; p < port_num; p++) begin
                de_cnt[p] <= 0;
            end
        end
        if (arst || !chk_en) begin
            synced = '0;
        end else begin
            if (misaligned) begin
                report_mismatch("misaligned high on an aligned stream");
            end
            for (int p = 0; p < port_num; p++) begin
                idx = {pix_out[p].g, pix_out[p].b};
                if (p >= port_cnt) begin
                    if (pix_out[p] != '0) begin
                        report_mismatch($sformatf("idle port %0d output not zero", p));
                    end
                end else if (pix_out[p].de != pix_out[0].de) begin
                    report_mismatch($sformatf("port %0d de differs from port 0", p));
                end else if (pix_out[p].de) begin
                    if (pix_out[p].r != chan_t'(p)) begin
                        report_mismatch($sformatf("port %0d carries tag %0d", p, pix_out[p].r));
                    end
                    // arming eats the first pixel of a line
                    if (!synced[p] && idx % line_len != 1) begin
                        report_mismatch($sformatf("port %0d starts at index %0d", p, idx));
                    end
                    if (synced[p] && idx != exp_idx[p]) begin
                        report_mismatch($sformatf("port %0d index %0d, expected %0d",
                                                  p, idx, exp_idx[p]));
                    end
                    exp_idx[p] = idx + 1;
                    synced[p]  = 1'b1;
                    de_cnt[p] <= de_cnt[p] + 1;
                end
            end
        end
    end

    `include "deskew_tests.svh"

    initial begin
        arst         = 1'b1;
        port_cnt     = port_cnt_t'(port_num);
        pix_in       = '0;
        stream_on    = 1'b0;
        fault_on     = 1'b0;
        garbage_hi   = 1'b0;
        chk_en       = 1'b0;
        t_cnt        = 0;
        seed         = 32'hd585c9b7;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        synced       = '0;
        for (int p = 0; p < port_num; p++) begin
            delay[p]   = 0;
            de_cnt[p]  = 0;
            exp_idx[p] = 0;
        end

        test_reset_values();
        test_aligned("no_skew", 4, 0, 1'b0);
        test_aligned("port_skew", 4, 2, 1'b0);
        test_aligned("two_ports", 2, 2, 1'b1);
        test_retry();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
